// File: Bender.yml
package:
  name: adc_monitor

sources:
  - files:
      - logic/adc_mon_pkg.sv
      - logic/i2c_events_if.sv
      - logic/reg_bus_if.sv
      - logic/i2c_bus_monitor.sv
      - logic/i2c_slave_ctrl.sv
      - logic/adc_result_capture.sv
      - logic/adc_reg_file.sv
      - logic/adc_monitor_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_adc_monitor.sv

// File: logic/adc_mon_pkg.sv
// ---------------------------------------------------------
// ADC monitor shared definitions
// Widths, sequencer channel map and I2C read map constants
// ---------------------------------------------------------
`default_nettype none

package adc_mon_pkg;

    // Sample and channel widths
    localparam int ADC_DATA_W = 12;
    localparam int NUM_CH     = 5;
    localparam int CH_ID_W    = 5;

    // Sequencer channel number for each result slot, slot 0 rightmost
    localparam logic [NUM_CH-1:0][CH_ID_W-1:0] CHANNEL_MAP =
        {5'd6, 5'd4, 5'd3, 5'd2, 5'd1};

    // ---------------------------------------------------------
    // I2C side
    // ---------------------------------------------------------
    localparam logic [6:0] DEFAULT_DEV_ADDR = 7'h50;
    localparam logic [7:0] DEVICE_ID        = 8'hAF;

    localparam int BYTE_IDX_W = 4;
    localparam int REG_PTR_W  = 3;

    // Register pointer of the control register
    localparam logic [REG_PTR_W-1:0] CTRL_PTR = 3'd0;

    // Byte read map
    localparam logic [BYTE_IDX_W-1:0] CTRL_IDX      = 4'd0;
    localparam logic [BYTE_IDX_W-1:0] ID_IDX        = 4'd1;
    localparam logic [BYTE_IDX_W-1:0] SLOT_BASE_IDX = 4'd2;
    localparam logic [BYTE_IDX_W-1:0] SLOT_END_IDX  = BYTE_IDX_W'(2 + 2 * NUM_CH);

    // Control byte bits that always read as set, bit 0 is the run bit
    localparam logic [7:0] CTRL_FIXED_BITS = 8'h02;

    // One complete set of results
    typedef logic [NUM_CH-1:0][ADC_DATA_W-1:0] adc_results_t;

endpackage

`default_nettype wire

// File: logic/adc_monitor_top.sv
// ---------------------------------------------------------
// ADC monitor top level
// I2C register slave over captured ADC sequencer results
// ---------------------------------------------------------
`default_nettype none

module adc_monitor_top
    import adc_mon_pkg::*;
#(
    parameter logic [6:0] dev_addr = DEFAULT_DEV_ADDR
) (
    input  logic                  clk_core,
    input  logic                  reset_n,
    // I2C, SDA split into input and open-drain pull-down
    input  logic                  scl,
    input  logic                  sda_in,
    output logic                  sda_low,
    // Sequencer response stream
    input  logic                  resp_valid,
    input  logic [CH_ID_W-1:0]    resp_channel,
    input  logic [ADC_DATA_W-1:0] resp_data,
    input  logic                  resp_endofpacket,
    output logic                  adc_run
);

    i2c_events_if ev_if ();
    reg_bus_if    reg_if ();
    adc_results_t adc_results;

    // ---------------------------------------------------------
    // I2C path
    // ---------------------------------------------------------
    i2c_bus_monitor u_bus_monitor (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .scl      (scl),
        .sda_in   (sda_in),
        .ev       (ev_if.driver)
    );

    i2c_slave_ctrl #(
        .dev_addr (dev_addr)
    ) u_slave_ctrl (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .ev       (ev_if.receiver),
        .regs     (reg_if.master),
        .sda_low  (sda_low)
    );

    adc_reg_file u_reg_file (
        .clk_core    (clk_core),
        .reset_n     (reset_n),
        .regs        (reg_if.slave),
        .adc_results (adc_results),
        .adc_run     (adc_run)
    );

    // ---------------------------------------------------------
    // Sequencer results
    // ---------------------------------------------------------
    adc_result_capture u_capture (
        .clk_core         (clk_core),
        .reset_n          (reset_n),
        .resp_valid       (resp_valid),
        .resp_channel     (resp_channel),
        .resp_data        (resp_data),
        .resp_endofpacket (resp_endofpacket),
        .adc_results      (adc_results)
    );

endmodule

`default_nettype wire

// File: logic/adc_reg_file.sv
// ---------------------------------------------------------
// ADC monitor registers
// Run control bit and the byte read map
// ---------------------------------------------------------
`default_nettype none

module adc_reg_file
    import adc_mon_pkg::*;
(
    input  logic         clk_core,
    input  logic         reset_n,
    reg_bus_if.slave     regs,
    input  adc_results_t adc_results,
    output logic         adc_run
);

    // Byte offset into the slot area, bit 0 selects the high byte
    logic [BYTE_IDX_W-1:0] slot_off;
    logic [ADC_DATA_W-1:0] sample;

    // Sequencer run level
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            adc_run <= 1'b0;
        end else if (regs.wr_en) begin
            adc_run <= regs.wr_data[0];
        end
    end

    // ---------------------------------------------------------
    // Read map decode
    // ---------------------------------------------------------
    always_comb begin
        slot_off = regs.byte_idx - SLOT_BASE_IDX;
        sample   = '0;
        for (int i = 0; i < NUM_CH; i++) begin
            if (slot_off[BYTE_IDX_W-1:1] == i) begin
                sample = adc_results[i];
            end
        end

        if (regs.byte_idx == CTRL_IDX) begin
            regs.rd_data = CTRL_FIXED_BITS | {7'b0, adc_run};
        end else if (regs.byte_idx == ID_IDX) begin
            regs.rd_data = DEVICE_ID;
        end else if (regs.byte_idx < SLOT_END_IDX) begin
            // Low byte first, upper nibble zero-extended
            regs.rd_data = slot_off[0] ? 8'(sample >> 8) : sample[7:0];
        end else begin
            regs.rd_data = 8'h00;
        end
    end

endmodule

`default_nettype wire

// File: logic/adc_result_capture.sv
// ---------------------------------------------------------
// ADC result capture
// Sorts sequencer beats into slots, publishes on endofpacket
// ---------------------------------------------------------
`default_nettype none

module adc_result_capture
    import adc_mon_pkg::*;
(
    input  logic                  clk_core,
    input  logic                  reset_n,
    input  logic                  resp_valid,
    input  logic [CH_ID_W-1:0]    resp_channel,
    input  logic [ADC_DATA_W-1:0] resp_data,
    input  logic                  resp_endofpacket,
    output adc_results_t          adc_results
);

    // Latest sample per slot, not yet published
    adc_results_t raw_q;
    // Raw set with the current beat merged in
    adc_results_t merged;

    always_comb begin
        merged = raw_q;
        for (int i = 0; i < NUM_CH; i++) begin
            if (resp_valid && (resp_channel == CHANNEL_MAP[i])) begin
                merged[i] = resp_data;
            end
        end
    end

    // Unmapped channels leave merged equal to raw_q
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            raw_q       <= '0;
            adc_results <= '0;
        end else begin
            raw_q <= merged;
            if (resp_valid && resp_endofpacket) begin
                adc_results <= merged;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/i2c_bus_monitor.sv
// ---------------------------------------------------------
// I2C line monitor
// Synchronizes SCL and SDA, flags START, STOP and SCL edges
// ---------------------------------------------------------
`default_nettype none

module i2c_bus_monitor (
    input  logic           clk_core,
    input  logic           reset_n,
    input  logic           scl,
    input  logic           sda_in,
    i2c_events_if.driver   ev
);

    // Bits 1:0 are the synchronizer, bit 2 keeps the previous level
    logic [2:0] scl_sh;
    logic [2:0] sda_sh;

    // Bus idles high
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            scl_sh <= 3'b111;
            sda_sh <= 3'b111;
        end else begin
            scl_sh <= {scl_sh[1:0], scl};
            sda_sh <= {sda_sh[1:0], sda_in};
        end
    end

    // ---------------------------------------------------------
    // Event strobes
    // ---------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            ev.scl_rise <= 1'b0;
            ev.scl_fall <= 1'b0;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
        end else begin
            ev.scl_rise <= scl_sh[1] & ~scl_sh[2];
            ev.scl_fall <= ~scl_sh[1] & scl_sh[2];
            // SDA moving while SCL stays high
            ev.start    <= ~sda_sh[1] & sda_sh[2] & scl_sh[1] & scl_sh[2];
            ev.stop     <= sda_sh[1] & ~sda_sh[2] & scl_sh[1] & scl_sh[2];
        end
    end

    // Same pipeline depth as the strobes
    assign ev.sda = sda_sh[2];

endmodule

`default_nettype wire

// File: logic/i2c_events_if.sv
// ---------------------------------------------------------
// I2C bus events from the line monitor to the slave engine
// ---------------------------------------------------------
`default_nettype none

interface i2c_events_if ();

    // One-cycle strobes
    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    // Synchronized SDA level
    logic sda;

    modport driver (output start, stop, scl_rise, scl_fall, sda);
    modport receiver (input start, stop, scl_rise, scl_fall, sda);

endinterface

`default_nettype wire

// File: logic/i2c_slave_ctrl.sv
// ---------------------------------------------------------
// I2C slave engine
// Address match, ACK, register pointer and byte transmit
// ---------------------------------------------------------
`default_nettype none

module i2c_slave_ctrl
    import adc_mon_pkg::*;
#(
    parameter logic [6:0] dev_addr = DEFAULT_DEV_ADDR
) (
    input  logic            clk_core,
    input  logic            reset_n,
    i2c_events_if.receiver  ev,
    reg_bus_if.master       regs,
    output logic            sda_low
);

    // Rising SCL edges seen in the current byte, 8 means ACK slot
    logic [3:0]           bit_cnt;
    logic [7:0]           rx_shift;
    logic [7:0]           tx_shift;
    logic                 sel;
    logic                 rw;
    logic                 ptr_set;
    logic                 wr_done;
    logic                 ignore;
    logic [REG_PTR_W-1:0] reg_ptr;

    logic ack_slot;
    logic addr_match;
    logic reading;
    logic tx_load;
    logic tx_shift_en;
    logic ctrl_write;

    assign ack_slot   = (bit_cnt == 4'd8);
    assign addr_match = (rx_shift[7:1] == dev_addr);
    assign reading    = sel && rw;

    // Byte loads on the SCL fall that follows the ACK bit
    assign tx_load     = ev.scl_fall && !ignore && reading && (bit_cnt == 4'd0);
    assign tx_shift_en = ev.scl_fall && !ignore && reading && !ack_slot && (bit_cnt != 4'd0);

    // Second data byte of a write with pointer 0, taken on the ACK rise
    assign ctrl_write = ev.scl_rise && ack_slot && !ignore && sel && !rw && ptr_set &&
                        !wr_done && (reg_ptr == CTRL_PTR);

    assign regs.wr_en   = ctrl_write;
    assign regs.wr_data = rx_shift;

    // ---------------------------------------------------------
    // Data shift registers
    // ---------------------------------------------------------
    always_ff @(posedge clk_core) begin
        if (ev.scl_rise && !ignore && !ack_slot) begin
            rx_shift <= {rx_shift[6:0], ev.sda};
        end
        if (tx_load) begin
            tx_shift <= {regs.rd_data[6:0], 1'b0};
        end else if (tx_shift_en) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    // ---------------------------------------------------------
    // Protocol state
    // ---------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt       <= '0;
            sel           <= 1'b0;
            rw            <= 1'b0;
            ptr_set       <= 1'b0;
            wr_done       <= 1'b0;
            ignore        <= 1'b1;
            reg_ptr       <= '0;
            regs.byte_idx <= '0;
            sda_low       <= 1'b0;
        end else if (ev.start || ev.stop) begin
            bit_cnt <= '0;
            sel     <= 1'b0;
            rw      <= 1'b0;
            ptr_set <= 1'b0;
            wr_done <= 1'b0;
            // Idle after STOP until the next START
            ignore  <= ev.stop;
            sda_low <= 1'b0;
        end else if (!ignore) begin
            if (ev.scl_rise) begin
                if (!ack_slot) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    bit_cnt <= '0;
                    if (!sel) begin
                        // Address was matched on the fall before
                        sel           <= 1'b1;
                        rw            <= rx_shift[0];
                        regs.byte_idx <= {reg_ptr, 1'b0};
                    end else if (!rw) begin
                        if (!ptr_set) begin
                            ptr_set <= 1'b1;
                            reg_ptr <= rx_shift[REG_PTR_W-1:0];
                        end else if (ctrl_write) begin
                            wr_done <= 1'b1;
                        end
                    end else if (ev.sda) begin
                        // Master NACK ends the read
                        ignore <= 1'b1;
                    end
                end
            end else if (ev.scl_fall) begin
                if (ack_slot) begin
                    if (!sel && !addr_match) begin
                        ignore <= 1'b1;
                    end else begin
                        // ACK own address and written bytes, release for master ACK
                        sda_low <= !reading;
                    end
                end else if (tx_load) begin
                    sda_low       <= !regs.rd_data[7];
                    regs.byte_idx <= regs.byte_idx + 1'b1;
                end else if (tx_shift_en) begin
                    sda_low <= !tx_shift[7];
                end else begin
                    sda_low <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_bus_if.sv
// ---------------------------------------------------------
// Byte-wide register access between I2C engine and registers
// ---------------------------------------------------------
`default_nettype none

interface reg_bus_if
    import adc_mon_pkg::*;
();

    logic [BYTE_IDX_W-1:0] byte_idx;
    // Combinational from byte_idx
    logic [7:0]            rd_data;
    // Single-cycle write of the control register
    logic                  wr_en;
    logic [7:0]            wr_data;

    modport master (output byte_idx, wr_en, wr_data, input rd_data);
    modport slave (input byte_idx, wr_en, wr_data, output rd_data);

endinterface

`default_nettype wire

// File: sources.f
+incdir+tb
logic/adc_mon_pkg.sv
logic/i2c_events_if.sv
logic/reg_bus_if.sv
logic/i2c_bus_monitor.sv
logic/i2c_slave_ctrl.sv
logic/adc_result_capture.sv
logic/adc_reg_file.sv
logic/adc_monitor_top.sv
tb/tb_adc_monitor.sv

// File: tb/i2c_master_bfm.svh
// ---------------------------------------------------------
// Bit-level I2C master for the ADC monitor testbench
// START, STOP and byte transfers paced by clk_core
// ---------------------------------------------------------
`ifndef I2C_MASTER_BFM_SVH
`define I2C_MASTER_BFM_SVH

// SCL high and low phase in clk_core cycles
localparam int SCL_HALF = 10;
// SDA hold after the SCL fall
localparam int SDA_HOLD = 2;

task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk_core);
endtask

// One SCL pulse, SDA sampled in the middle of the high phase
task automatic clock_bit(input logic b, output logic s);
    m_pull <= ~b;
    wait_clocks(SCL_HALF);
    scl <= 1'b1;
    wait_clocks(SCL_HALF / 2);
    s = sda_in;
    wait_clocks(SCL_HALF - SCL_HALF / 2);
    scl <= 1'b0;
    wait_clocks(SDA_HOLD);
endtask

// Also serves as repeated START when SCL is low
task automatic i2c_start();
    m_pull <= 1'b0;
    wait_clocks(SCL_HALF);
    scl <= 1'b1;
    wait_clocks(SCL_HALF);
    m_pull <= 1'b1;
    wait_clocks(SCL_HALF);
    scl <= 1'b0;
    wait_clocks(SDA_HOLD);
endtask

task automatic i2c_stop();
    m_pull <= 1'b1;
    wait_clocks(SCL_HALF);
    scl <= 1'b1;
    wait_clocks(SCL_HALF);
    m_pull <= 1'b0;
    wait_clocks(SCL_HALF);
endtask

task automatic write_byte(input logic [7:0] data, output logic ack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
        clock_bit(data[i], s);
    end
    clock_bit(1'b1, s);
    ack = ~s;
endtask

task automatic read_byte(output logic [7:0] data, input logic nack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
        clock_bit(1'b1, s);
        data[i] = s;
    end
    clock_bit(nack, s);
endtask

`endif

// File: tb/tb_adc_monitor.sv
// ---------------------------------------------------------
// ADC monitor testbench
// I2C register access and sequencer capture against a model
// ---------------------------------------------------------
`default_nettype none

module tb_adc_monitor
    import adc_mon_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] SLAVE_ADDR     = 7'h50;
    localparam logic [6:0] OTHER_ADDR     = 7'h51;
    localparam logic [7:0] EXP_ID         = 8'hAF;
    localparam int         CLK_PERIOD_NS  = 40;
    localparam int         NUM_TESTS      = 6;
    localparam int         BYTES_PER_TEST = 32;

    logic                  clk_core = 1'b0;
    logic                  reset_n;
    logic                  scl;
    logic                  m_pull;
    wire                   sda_in;
    logic                  sda_low;
    logic                  resp_valid;
    logic [CH_ID_W-1:0]    resp_channel;
    logic [ADC_DATA_W-1:0] resp_data;
    logic                  resp_endofpacket;
    logic                  adc_run;

    integer seed = 32'h32d6_a56a;
    int     cycle_cnt = 0;
    int     test_errors;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    int     sva_errors = 0;
    bit     watch_quiet = 1'b0;

    // Scoreboard state
    logic [ADC_DATA_W-1:0] raw_model [5];
    logic [ADC_DATA_W-1:0] pub_model [5];
    logic                  run_model;
    logic [7:0]            rd_buf [16];

    `include "i2c_master_bfm.svh"

    localparam int SCL_PERIOD_NS = (2 * SCL_HALF + SDA_HOLD) * CLK_PERIOD_NS;

    // Open-drain SDA, low when either side pulls
    assign sda_in = ~(sda_low | m_pull);

    adc_monitor_top #(
        .dev_addr (SLAVE_ADDR)
    ) UUT (
        .clk_core         (clk_core),
        .reset_n          (reset_n),
        .scl              (scl),
        .sda_in           (sda_in),
        .sda_low          (sda_low),
        .resp_valid       (resp_valid),
        .resp_channel     (resp_channel),
        .resp_data        (resp_data),
        .resp_endofpacket (resp_endofpacket),
        .adc_run          (adc_run)
    );

    always #20 clk_core = ~clk_core;

    always @(posedge clk_core) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ---------------------------------------------------------
    // Concurrent checks
    // ---------------------------------------------------------
    reset_outputs_low: assert property (@(posedge clk_core)
        (!reset_n && cycle_cnt != 0) |-> (!sda_low && !adc_run))
        else begin
            sva_errors++;
            $display("sda_low or adc_run was not held low during reset");
        end

    quiet_for_other_address: assert property (@(posedge clk_core) watch_quiet |-> !sda_low)
        else begin
            test_errors++;
            $display("sda_low was driven during a transfer to another address");
        end

    // Sequencer channel to result slot, -1 when unmapped
    function automatic int slot_of(input int ch);
        case (ch)
            1: return 0;
            2: return 1;
            3: return 2;
            4: return 3;
            6: return 4;
            default: return -1;
        endcase
    endfunction

    function automatic logic [7:0] exp_byte(input int idx);
        int s;
        s = (idx - 2) / 2;
        if (idx == 0) return run_model ? 8'h03 : 8'h02;
        if (idx == 1) return EXP_ID;
        if (idx < 12) begin
            return (idx % 2 == 0) ? pub_model[s][7:0] : {4'h0, pub_model[s][11:8]};
        end
        return 8'h00;
    endfunction

    task automatic send_sequence(input bit with_eop);
        logic [31:0] r;
        int          slot;
        @(posedge clk_core);
        for (int ch = 1; ch <= 6; ch++) begin
            r = $random(seed);
            resp_valid       <= 1'b1;
            resp_channel     <= CH_ID_W'(ch);
            resp_data        <= r[ADC_DATA_W-1:0];
            resp_endofpacket <= with_eop && (ch == 6);
            slot = slot_of(ch);
            if (slot >= 0) raw_model[slot] = r[ADC_DATA_W-1:0];
            @(posedge clk_core);
        end
        resp_valid       <= 1'b0;
        resp_endofpacket <= 1'b0;
        if (with_eop) pub_model = raw_model;
        wait_clocks(2);
    endtask

    task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
        assert (act === exp) else begin
            test_errors++;
            $display("ERROR %s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_ack(input string name, input logic ack, input logic want);
        assert (ack === want) else begin
            test_errors++;
            $display("%s: slave %s the byte unexpectedly", name,
                     ack ? "acknowledged" : "did not acknowledge");
        end
    endtask

    // START, address write and pointer byte, bus left open
    task automatic set_pointer(input string name, input logic [7:0] ptr);
        logic ack;
        i2c_start();
        write_byte({SLAVE_ADDR, 1'b0}, ack);
        check_ack(name, ack, 1'b1);
        write_byte(ptr, ack);
        check_ack(name, ack, 1'b1);
    endtask

    task automatic write_reg(input string name, input logic [7:0] ptr, input logic [7:0] data);
        logic ack;
        set_pointer(name, ptr);
        write_byte(data, ack);
        check_ack(name, ack, 1'b1);
        i2c_stop();
    endtask

    // Repeated START, read n bytes with NACK on the last, STOP
    task automatic read_burst(input string name, input int base_idx, input int n);
        logic ack;
        i2c_start();
        write_byte({SLAVE_ADDR, 1'b1}, ack);
        check_ack(name, ack, 1'b1);
        for (int i = 0; i < n; i++) begin
            read_byte(rd_buf[i], i == n - 1);
        end
        i2c_stop();
        for (int i = 0; i < n; i++) begin
            check_value(name, exp_byte(base_idx + i), rd_buf[i]);
        end
    endtask

    task automatic read_check(input string name, input logic [7:0] ptr, input int n);
        set_pointer(name, ptr);
        read_burst(name, 2 * ptr, n);
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_cnt++;
            $display("Test %-16s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %-16s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // ---------------------------------------------------------
    // Test sequence
    // ---------------------------------------------------------
    initial begin
        logic ack;
        reset_n          = 1'b0;
        scl              = 1'b1;
        m_pull           = 1'b0;
        resp_valid       = 1'b0;
        resp_channel     = '0;
        resp_data        = '0;
        resp_endofpacket = 1'b0;
        run_model        = 1'b0;
        test_errors      = 0;
        for (int i = 0; i < 5; i++) begin
            raw_model[i] = '0;
            pub_model[i] = '0;
        end
        repeat (4) @(posedge clk_core);
        reset_n <= 1'b1;
        wait_clocks(4);

        check_value("reset_state", 8'h00, {7'b0, adc_run});
        read_check("reset_state", 8'd0, 2);
        end_test("reset_state");

        write_reg("run_control", 8'd0, 8'h01);
        run_model = 1'b1;
        check_value("run_control", 8'h01, {7'b0, adc_run});
        read_check("run_control", 8'd0, 1);
        write_reg("run_control", 8'd0, 8'h00);
        run_model = 1'b0;
        check_value("run_control", 8'h00, {7'b0, adc_run});
        end_test("run_control");

        send_sequence(1'b1);
        read_check("full_sequence", 8'd1, 10);
        end_test("full_sequence");

        // Raw beats stay hidden until endofpacket
        send_sequence(1'b0);
        read_check("hold_until_eop", 8'd1, 10);
        send_sequence(1'b1);
        read_check("hold_until_eop", 8'd1, 10);
        end_test("hold_until_eop");

        watch_quiet = 1'b1;
        i2c_start();
        write_byte({OTHER_ADDR, 1'b0}, ack);
        check_ack("other_address", ack, 1'b0);
        write_byte(8'h00, ack);
        check_ack("other_address", ack, 1'b0);
        write_byte(8'h01, ack);
        check_ack("other_address", ack, 1'b0);
        i2c_stop();
        watch_quiet = 1'b0;
        check_value("other_address", {7'b0, run_model}, {7'b0, adc_run});
        end_test("other_address");

        // Byte after slot 0 low is a high byte with MSB clear
        set_pointer("nack_release", 8'd1);
        i2c_start();
        write_byte({SLAVE_ADDR, 1'b1}, ack);
        check_ack("nack_release", ack, 1'b1);
        read_byte(rd_buf[0], 1'b1);
        wait_clocks(2 * SCL_HALF);
        check_value("nack_release", 8'h00, {7'b0, sda_low});
        check_value("nack_release", exp_byte(2), rd_buf[0]);
        read_burst("nack_release", 2, 2);
        end_test("nack_release");

        $display("Summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && sva_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Watchdog sized from the test count and byte budget
    initial begin
        #(NUM_TESTS * BYTES_PER_TEST * 20 * SCL_PERIOD_NS + 100_000);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
